// ==== source/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and register file sizes
`define CORE_XLEN       32
`define CORE_ARCH_REGS  32
`define CORE_PHYS_REGS  64

// queue depths
`define CORE_IQ_DEPTH   8
`define CORE_FL_DEPTH   32   // phys minus arch

// rv32i major opcodes
`define CORE_OPC_LUI     7'b0110111
`define CORE_OPC_OP_IMM  7'b0010011
`define CORE_OPC_OP      7'b0110011

`endif

// ==== source/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

    typedef logic [31:0]                        inst_t;
    typedef logic [`CORE_XLEN-1:0]              data_t;
    typedef logic [$clog2(`CORE_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`CORE_PHYS_REGS)-1:0] phys_reg_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b   // lui
    } alu_op_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      b_imm;    // operand b from immediate
        data_t     imm;
        arch_reg_t rd;
        phys_reg_t pd;       // new mapping of rd
        phys_reg_t old_pd;   // released at write-back
        phys_reg_t ps1;
        phys_reg_t ps2;
        logic      we;
    } uop_t;

endpackage

// ==== source/fifo_queue.sv ====
module fifo_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t head_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = count_q == FULL_CNT;
    assign empty_o = count_q == '0;
    assign head_o  = mem[head_q];

    assign do_push = push_i && !full_o;    // drop on full
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= (tail_q == LAST_IDX) ? '0 : tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= (head_q == LAST_IDX) ? '0 : head_q + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== source/decode_rename.sv ====
`include "core_macros.svh"

module decode_rename (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::inst_t     inst_i,
    input  logic                inst_empty_i,
    input  core_pkg::data_t     rs1_value_i,
    input  core_pkg::data_t     rs2_value_i,
    input  logic                wb_valid_i,
    input  core_pkg::phys_reg_t wb_pd_i,
    input  logic                free_valid_i,
    input  core_pkg::phys_reg_t free_pd_i,
    output logic                inst_pop_o,
    output core_pkg::phys_reg_t rs1_pd_o,
    output core_pkg::phys_reg_t rs2_pd_o,
    output logic                issue_valid_o,
    output core_pkg::uop_t      issue_uop_o,
    output core_pkg::data_t     issue_a_o,
    output core_pkg::data_t     issue_b_o
);

    localparam int FRESH_W = $clog2(`CORE_PHYS_REGS) + 1;

    core_pkg::phys_reg_t        rename_map [`CORE_ARCH_REGS];
    logic [`CORE_PHYS_REGS-1:0] ready_q;
    logic [FRESH_W-1:0]         fresh_cnt;    // next never-used register
    logic                       fresh_avail;
    core_pkg::phys_reg_t        fl_head;
    logic                       fl_empty;
    logic                       fl_pop;
    core_pkg::phys_reg_t        new_pd;

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    core_pkg::arch_reg_t        rd;
    core_pkg::arch_reg_t        rs1;
    core_pkg::arch_reg_t        rs2;
    logic                       use_rs1;
    logic                       use_rs2;
    logic                       supported;
    logic                       b_imm;
    logic                       dest_we;
    core_pkg::data_t            imm;
    core_pkg::alu_op_t          alu_op;

    // shared funct3 map of op and op-imm
    function automatic core_pkg::alu_op_t f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  return core_pkg::alu_sll;
            3'b010:  return core_pkg::alu_slt;
            3'b011:  return core_pkg::alu_sltu;
            3'b100:  return core_pkg::alu_xor;
            3'b101:  return alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  return core_pkg::alu_or;
            default: return core_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        opcode    = inst_i[6:0];
        funct3    = inst_i[14:12];
        alu_op    = core_pkg::alu_add;
        b_imm     = 1'b1;
        imm       = {{20{inst_i[31]}}, inst_i[31:20]};  // i-type
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        supported = 1'b0;
        case (opcode)
            `CORE_OPC_LUI: begin
                supported = 1'b1;
                alu_op    = core_pkg::alu_pass_b;
                imm       = {inst_i[31:12], 12'b0};
            end
            `CORE_OPC_OP_IMM: begin
                supported = 1'b1;
                use_rs1   = 1'b1;
                alu_op    = f3_op(funct3, inst_i[30] && funct3 == 3'b101);  // srai only
            end
            `CORE_OPC_OP: begin
                supported = !inst_i[25];    // funct7 bit 0 marks mul/div
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                b_imm     = 1'b0;
                alu_op    = f3_op(funct3, inst_i[30]);
            end
            default: ;
        endcase
    end

    // unused sources look up x0, which is always ready
    assign rd  = inst_i[11:7];
    assign rs1 = use_rs1 ? inst_i[19:15] : '0;
    assign rs2 = use_rs2 ? inst_i[24:20] : '0;

    assign rs1_pd_o = rename_map[rs1];
    assign rs2_pd_o = rename_map[rs2];
    assign dest_we  = supported && rd != '0;

    assign fresh_avail = fresh_cnt < FRESH_W'(`CORE_PHYS_REGS);
    assign new_pd      = fresh_avail ? core_pkg::phys_reg_t'(fresh_cnt) : fl_head;

    assign issue_valid_o = !inst_empty_i && ready_q[rs1_pd_o] && ready_q[rs2_pd_o]
                           && (!dest_we || fresh_avail || !fl_empty);
    assign inst_pop_o    = issue_valid_o;
    assign fl_pop        = issue_valid_o && dest_we && !fresh_avail;

    assign issue_a_o = rs1_value_i;
    assign issue_b_o = rs2_value_i;

    always_comb begin
        issue_uop_o.alu_op = alu_op;
        issue_uop_o.b_imm  = b_imm;
        issue_uop_o.imm    = imm;
        issue_uop_o.rd     = rd;
        issue_uop_o.pd     = dest_we ? new_pd : '0;
        issue_uop_o.old_pd = dest_we ? rename_map[rd] : '0;
        issue_uop_o.ps1    = rs1_pd_o;
        issue_uop_o.ps2    = rs2_pd_o;
        issue_uop_o.we     = dest_we;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_ARCH_REGS; i++) begin
                rename_map[i] <= core_pkg::phys_reg_t'(i);   // identity map
            end
            ready_q   <= '1;
            fresh_cnt <= FRESH_W'(`CORE_ARCH_REGS);
        end else begin
            if (wb_valid_i) begin
                ready_q[wb_pd_i] <= 1'b1;
            end
            if (issue_valid_o && dest_we) begin
                rename_map[rd]  <= new_pd;
                ready_q[new_pd] <= 1'b0;   // pending until write-back
                if (fresh_avail) begin
                    fresh_cnt <= fresh_cnt + 1'b1;
                end
            end
        end
    end

    fifo_queue #(
        .payload_t (core_pkg::phys_reg_t),
        .DEPTH     (`CORE_FL_DEPTH)
    ) i_free_list (
        .clk         (clk),
        .rst         (rst),
        .push_i      (free_valid_i),
        .push_data_i (free_pd_i),
        .pop_i       (fl_pop),
        .head_o      (fl_head),
        .full_o      (),
        .empty_o     (fl_empty)
    );

endmodule

// ==== source/alu_execute.sv ====
`include "core_macros.svh"

module alu_execute (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid_i,
    input  core_pkg::uop_t  issue_uop_i,
    input  core_pkg::data_t issue_a_i,
    input  core_pkg::data_t issue_b_i,
    output logic            exec_valid_o,
    output core_pkg::uop_t  exec_uop_o,
    output core_pkg::data_t exec_value_o
);

    core_pkg::data_t op_b;
    core_pkg::data_t result;

    assign op_b = issue_uop_i.b_imm ? issue_uop_i.imm : issue_b_i;

    always_comb begin
        case (issue_uop_i.alu_op)
            core_pkg::alu_add:    result = issue_a_i + op_b;
            core_pkg::alu_sub:    result = issue_a_i - op_b;
            core_pkg::alu_sll:    result = issue_a_i << op_b[4:0];
            core_pkg::alu_slt:    result = {{(`CORE_XLEN-1){1'b0}}, $signed(issue_a_i) < $signed(op_b)};
            core_pkg::alu_sltu:   result = {{(`CORE_XLEN-1){1'b0}}, issue_a_i < op_b};
            core_pkg::alu_xor:    result = issue_a_i ^ op_b;
            core_pkg::alu_srl:    result = issue_a_i >> op_b[4:0];
            core_pkg::alu_sra:    result = core_pkg::data_t'($signed(issue_a_i) >>> op_b[4:0]);
            core_pkg::alu_or:     result = issue_a_i | op_b;
            core_pkg::alu_and:    result = issue_a_i & op_b;
            core_pkg::alu_pass_b: result = op_b;   // lui
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid_o <= 1'b0;
        end else begin
            exec_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        exec_uop_o   <= issue_uop_i;
        exec_value_o <= result;
    end

endmodule

// ==== source/result_writeback.sv ====
`include "core_macros.svh"

module result_writeback (
    input  logic                clk,
    input  logic                rst,
    input  logic                exec_valid_i,
    input  core_pkg::uop_t      exec_uop_i,
    input  core_pkg::data_t     exec_value_i,
    input  core_pkg::phys_reg_t rs1_pd_i,
    input  core_pkg::phys_reg_t rs2_pd_i,
    output core_pkg::data_t     rs1_value_o,
    output core_pkg::data_t     rs2_value_o,
    output logic                wb_valid_o,
    output core_pkg::phys_reg_t wb_pd_o,
    output logic                free_valid_o,
    output core_pkg::phys_reg_t free_pd_o,
    output logic                commit_valid_o,
    output core_pkg::arch_reg_t commit_rd_o,
    output core_pkg::data_t     commit_value_o
);

    core_pkg::data_t prf [`CORE_PHYS_REGS];

    // p0 is hardwired zero
    assign rs1_value_o = (rs1_pd_i == '0) ? '0 : prf[rs1_pd_i];
    assign rs2_value_o = (rs2_pd_i == '0) ? '0 : prf[rs2_pd_i];

    // ready bit and regfile update on the same edge
    assign wb_valid_o   = exec_valid_i && exec_uop_i.we;
    assign wb_pd_o      = exec_uop_i.pd;
    assign free_valid_o = wb_valid_o && exec_uop_i.old_pd != '0;
    assign free_pd_o    = exec_uop_i.old_pd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_PHYS_REGS; i++) begin
                prf[i] <= '0;   // arch state starts at zero
            end
        end else if (wb_valid_o) begin
            prf[exec_uop_i.pd] <= exec_value_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= exec_valid_i;
        end
    end

    // no-write instructions report rd 0, value 0
    always_ff @(posedge clk) begin
        commit_rd_o    <= exec_uop_i.we ? exec_uop_i.rd : '0;
        commit_value_o <= exec_uop_i.we ? exec_value_i : '0;
    end

endmodule

// ==== source/rename_core.sv ====
`include "core_macros.svh"

module rename_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  core_pkg::inst_t     inst_i,
    output logic                iq_full_o,
    output logic                commit_valid_o,
    output core_pkg::arch_reg_t commit_rd_o,
    output core_pkg::data_t     commit_value_o
);

    core_pkg::inst_t     inst_head;
    logic                inst_empty;
    logic                inst_pop;
    core_pkg::phys_reg_t rs1_pd;
    core_pkg::phys_reg_t rs2_pd;
    core_pkg::data_t     rs1_value;
    core_pkg::data_t     rs2_value;
    logic                issue_valid;
    core_pkg::uop_t      issue_uop;
    core_pkg::data_t     issue_a;
    core_pkg::data_t     issue_b;
    logic                exec_valid;
    core_pkg::uop_t      exec_uop;
    core_pkg::data_t     exec_value;
    logic                wb_valid;
    core_pkg::phys_reg_t wb_pd;
    logic                free_valid;
    core_pkg::phys_reg_t free_pd;

    fifo_queue #(
        .payload_t (core_pkg::inst_t),
        .DEPTH     (`CORE_IQ_DEPTH)
    ) i_inst_queue (
        .clk         (clk),
        .rst         (rst),
        .push_i      (inst_valid_i),
        .push_data_i (inst_i),
        .pop_i       (inst_pop),
        .head_o      (inst_head),
        .full_o      (iq_full_o),
        .empty_o     (inst_empty)
    );

    decode_rename i_decode_rename (
        .clk           (clk),
        .rst           (rst),
        .inst_i        (inst_head),
        .inst_empty_i  (inst_empty),
        .rs1_value_i   (rs1_value),
        .rs2_value_i   (rs2_value),
        .wb_valid_i    (wb_valid),
        .wb_pd_i       (wb_pd),
        .free_valid_i  (free_valid),
        .free_pd_i     (free_pd),
        .inst_pop_o    (inst_pop),
        .rs1_pd_o      (rs1_pd),
        .rs2_pd_o      (rs2_pd),
        .issue_valid_o (issue_valid),
        .issue_uop_o   (issue_uop),
        .issue_a_o     (issue_a),
        .issue_b_o     (issue_b)
    );

    alu_execute i_alu_execute (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .issue_a_i     (issue_a),
        .issue_b_i     (issue_b),
        .exec_valid_o  (exec_valid),
        .exec_uop_o    (exec_uop),
        .exec_value_o  (exec_value)
    );

    result_writeback i_result_writeback (
        .clk            (clk),
        .rst            (rst),
        .exec_valid_i   (exec_valid),
        .exec_uop_i     (exec_uop),
        .exec_value_i   (exec_value),
        .rs1_pd_i       (rs1_pd),
        .rs2_pd_i       (rs2_pd),
        .rs1_value_o    (rs1_value),
        .rs2_value_o    (rs2_value),
        .wb_valid_o     (wb_valid),
        .wb_pd_o        (wb_pd),
        .free_valid_o   (free_valid),
        .free_pd_o      (free_pd),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;
int check_count = 0;

// architectural state of the reference model
core_pkg::data_t     model_regs [32];
core_pkg::arch_reg_t exp_rd_q [$];
core_pkg::data_t     exp_value_q [$];

// executes one instruction in program order and queues its expected commit
task automatic model_execute(input core_pkg::inst_t inst);
    logic [6:0]          opc;
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic [4:0]          sh;
    core_pkg::arch_reg_t rd;
    core_pkg::data_t     a;
    core_pkg::data_t     b;
    core_pkg::data_t     res;
    logic                writes;
    opc    = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    rd     = inst[11:7];
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    res    = '0;
    writes = 1'b1;
    if (opc == `CORE_OPC_LUI) begin
        res = {inst[31:12], 12'h000};
    end else if (opc == `CORE_OPC_OP_IMM || (opc == `CORE_OPC_OP && f7 != 7'b0000001)) begin
        if (opc == `CORE_OPC_OP_IMM) begin
            b = {{20{inst[31]}}, inst[31:20]};
        end
        sh = b[4:0];
        case (f3)
            3'b000:  res = (opc == `CORE_OPC_OP && f7[5]) ? a - b : a + b;
            3'b001:  res = a << sh;
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = (a >> sh) | ((f7[5] && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
    end else begin
        writes = 1'b0;   // mul/div and unknown opcodes
    end
    if (rd == 5'd0) begin
        writes = 1'b0;
    end
    if (writes) begin
        model_regs[rd] = res;
        exp_rd_q.push_back(rd);
        exp_value_q.push_back(res);
    end else begin
        exp_rd_q.push_back('0);
        exp_value_q.push_back('0);
    end
endtask

task automatic compare_commit_rd(input core_pkg::arch_reg_t got, input core_pkg::arch_reg_t exp);
    check_count++;
    if (got !== exp) begin
        $display("** Error at time %0t: commit rd is x%0d, expected x%0d", $time, got, exp);
        error_count++;
    end
endtask

task automatic compare_commit_value(input core_pkg::data_t got, input core_pkg::data_t exp);
    check_count++;
    if (got !== exp) begin
        $display("** Error at time %0t: commit value is %08h, expected %08h", $time, got, exp);
        error_count++;
    end
endtask

`endif

// ==== testbench/tb_rename_core.sv ====
`include "core_macros.svh"

module tb_rename_core;

    localparam int PERIOD       = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_LEN   = 300;
    localparam int DIRECTED_LEN = 120;   // bound on pushes of the directed tests
    localparam int DRAIN_LIMIT  = 400;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (DIRECTED_LEN + RANDOM_LEN) * 20;

    logic                clk = 1'b0;
    logic                rst;
    logic                inst_valid_i;
    core_pkg::inst_t     inst_i;
    logic                iq_full_o;
    logic                commit_valid_o;
    core_pkg::arch_reg_t commit_rd_o;
    core_pkg::data_t     commit_value_o;

    int   push_count   = 0;
    int   commit_count = 0;
    int   test_count   = 0;
    logic seen_full    = 1'b0;

    `include "tb_checks.svh"

    rename_core i_dut (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .iq_full_o      (iq_full_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    // instruction encoders
    function automatic core_pkg::inst_t enc_u(input logic [19:0] imm, input core_pkg::arch_reg_t rd);
        return {imm, rd, `CORE_OPC_LUI};
    endfunction

    function automatic core_pkg::inst_t enc_i(input logic [11:0] imm, input core_pkg::arch_reg_t rs1,
                                              input logic [2:0] f3, input core_pkg::arch_reg_t rd);
        return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
    endfunction

    function automatic core_pkg::inst_t enc_r(input logic [6:0] f7, input core_pkg::arch_reg_t rs2,
                                              input core_pkg::arch_reg_t rs1, input logic [2:0] f3,
                                              input core_pkg::arch_reg_t rd);
        return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
    endfunction

    // commits sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            if (iq_full_o) begin
                seen_full = 1'b1;
            end
            if (commit_valid_o) begin
                commit_count++;
                if (exp_rd_q.size() == 0) begin
                    $display("commit at time %0t with no instruction outstanding", $time);
                    error_count++;
                end else begin
                    compare_commit_rd(commit_rd_o, exp_rd_q.pop_front());
                    compare_commit_value(commit_value_o, exp_value_q.pop_front());
                end
            end
        end
    end

    // entered and left at DRIVE_DELAY after a rising edge
    task automatic push_inst(input core_pkg::inst_t inst);
        while (iq_full_o) begin
            inst_valid_i = 1'b0;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        inst_valid_i = 1'b1;
        inst_i       = inst;
        model_execute(inst);
        push_count++;
        @(posedge clk);
        #DRIVE_DELAY;
        inst_valid_i = 1'b0;
    endtask

    task automatic wait_commits();
        int cycles;
        cycles = 0;
        while (exp_rd_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d instructions never committed by time %0t", exp_rd_q.size(), $time);
            error_count++;
            exp_rd_q.delete();
            exp_value_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %s done: %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_reset_and_constants();
        int errs;
        errs = error_count;
        for (int r = 1; r < 32; r++) begin
            push_inst(enc_i(12'h000, core_pkg::arch_reg_t'(r), 3'b000, core_pkg::arch_reg_t'(r)));
        end
        push_inst(enc_u(20'hdead0, 5'd1));
        push_inst(enc_i(12'h7ef, 5'd1, 3'b000, 5'd1));
        push_inst(enc_u(20'h00001, 5'd2));
        push_inst(enc_i(12'h800, 5'd2, 3'b000, 5'd2));   // negative immediate
        push_inst(enc_u(20'hfffff, 5'd3));
        push_inst(enc_i(12'hfff, 5'd3, 3'b000, 5'd3));
        wait_commits();
        report_test("reset_and_constants", errs);
    endtask

    task automatic test_op_imm_edges();
        int errs;
        errs = error_count;
        push_inst(enc_u(20'h80000, 5'd1));               // most negative
        push_inst(enc_i(12'hfff, 5'd0, 3'b000, 5'd2));   // all ones
        push_inst(enc_u(20'h80000, 5'd3));
        push_inst(enc_i(12'hfff, 5'd3, 3'b000, 5'd3));   // most positive
        for (int s = 1; s <= 3; s++) begin
            push_inst(enc_i(12'h01f, core_pkg::arch_reg_t'(s), 3'b001, 5'd10));
            push_inst(enc_i(12'h001, core_pkg::arch_reg_t'(s), 3'b101, 5'd11));
            push_inst(enc_i(12'h404, core_pkg::arch_reg_t'(s), 3'b101, 5'd12));  // srai 4
            push_inst(enc_i(12'hfff, core_pkg::arch_reg_t'(s), 3'b010, 5'd13));
            push_inst(enc_i(12'hfff, core_pkg::arch_reg_t'(s), 3'b011, 5'd14));
            push_inst(enc_i(12'h7ff, core_pkg::arch_reg_t'(s), 3'b010, 5'd15));
            push_inst(enc_i(12'hfff, core_pkg::arch_reg_t'(s), 3'b100, 5'd16));
            push_inst(enc_i(12'h555, core_pkg::arch_reg_t'(s), 3'b110, 5'd17));
            push_inst(enc_i(12'h800, core_pkg::arch_reg_t'(s), 3'b111, 5'd18));
        end
        wait_commits();
        report_test("op_imm_edges", errs);
    endtask

    task automatic test_dependent_chain();
        int errs;
        errs = error_count;
        push_inst(enc_u(20'h12345, 5'd5));
        push_inst(enc_i(12'h678, 5'd5, 3'b000, 5'd5));
        push_inst(enc_i(12'h003, 5'd0, 3'b000, 5'd4));
        push_inst(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
        push_inst(enc_r(7'h20, 5'd6, 5'd0, 3'b000, 5'd7));   // negate
        push_inst(enc_r(7'h20, 5'd4, 5'd7, 3'b101, 5'd8));   // sra
        push_inst(enc_r(7'h00, 5'd6, 5'd8, 3'b011, 5'd9));   // sltu
        push_inst(enc_r(7'h00, 5'd7, 5'd9, 3'b100, 5'd10));
        push_inst(enc_r(7'h00, 5'd4, 5'd10, 3'b001, 5'd11));
        push_inst(enc_r(7'h00, 5'd4, 5'd11, 3'b101, 5'd12));
        push_inst(enc_r(7'h00, 5'd5, 5'd12, 3'b010, 5'd13));
        push_inst(enc_r(7'h00, 5'd12, 5'd13, 3'b110, 5'd14));
        push_inst(enc_r(7'h00, 5'd11, 5'd14, 3'b111, 5'd15));
        wait_commits();
        report_test("dependent_chain", errs);
    endtask

    task automatic test_queue_full();
        int errs;
        int pushes_before;
        int commits_before;
        errs           = error_count;
        pushes_before  = push_count;
        commits_before = commit_count;
        seen_full      = 1'b0;
        // a chain on one register drains slower than it is pushed
        for (int n = 0; n < 32; n++) begin
            push_inst(enc_i(12'h001, 5'd9, 3'b000, 5'd9));
        end
        wait_commits();
        if (!seen_full) begin
            $display("instruction queue never reported full during the burst");
            error_count++;
        end
        if (commit_count - commits_before != push_count - pushes_before) begin
            $display("%0d pushes but %0d commits in the burst",
                     push_count - pushes_before, commit_count - commits_before);
            error_count++;
        end
        report_test("queue_full", errs);
    endtask

    task automatic test_x0_and_unsupported();
        int errs;
        errs = error_count;
        push_inst(enc_i(12'h005, 5'd0, 3'b000, 5'd0));
        push_inst(enc_u(20'habcde, 5'd0));
        push_inst({25'h155, 7'b0001011});               // custom opcode, rd x21
        push_inst(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd11));   // mul
        push_inst(enc_i(12'h007, 5'd0, 3'b000, 5'd12));
        push_inst(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd13));
        wait_commits();
        report_test("x0_and_unsupported", errs);
    endtask

    task automatic test_random_stream();
        int                  errs;
        int                  kind;
        logic [2:0]          f3;
        logic                alt;
        logic [11:0]         imm;
        core_pkg::arch_reg_t rd;
        core_pkg::arch_reg_t rs1;
        core_pkg::arch_reg_t rs2;
        core_pkg::inst_t     inst;
        errs = error_count;
        for (int n = 0; n < RANDOM_LEN; n++) begin
            kind = $urandom_range(0, 2);
            rd   = core_pkg::arch_reg_t'($urandom_range(0, 15));   // small set, more hazards
            rs1  = core_pkg::arch_reg_t'($urandom_range(0, 15));
            rs2  = core_pkg::arch_reg_t'($urandom_range(0, 15));
            f3   = 3'($urandom_range(0, 7));
            alt  = 1'($urandom_range(0, 1));
            imm  = 12'($urandom);
            case (kind)
                0: inst = enc_u(20'($urandom), rd);
                1: begin
                    if (f3 == 3'b001) begin
                        imm = {7'b0, imm[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm = {1'b0, alt, 5'b0, imm[4:0]};
                    end
                    inst = enc_i(imm, rs1, f3, rd);
                end
                default: begin
                    inst = enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd);
                end
            endcase
            push_inst(inst);
        end
        wait_commits();
        report_test("random_stream", errs);
    endtask

    initial begin
        void'($urandom(82));
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        test_reset_and_constants();
        test_op_imm_edges();
        test_dependent_chain();
        test_queue_full();
        test_x0_and_unsupported();
        test_random_stream();
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("watchdog expired at time %0t before the tests completed", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+source
+incdir+testbench
source/core_pkg.sv
source/fifo_queue.sv
source/decode_rename.sv
source/alu_execute.sv
source/result_writeback.sv
source/rename_core.sv
testbench/tb_rename_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rename_core -f flist.f -o tb_rename_core \
    && ./obj_dir/tb_rename_core > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
